//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module fetch_tb
	@out=$$(./obj_dir/Vfetch_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- rtl/fetch_apb_master.sv
module fetch_apb_master
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    fetch_mem_if.master mem,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output addr_t      paddr,
    input  inst_word_t prdata,
    input  logic       pready
);

    apb_state_t state;
    addr_t      addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (mem.req) state <= SETUP;
                SETUP:   state <= ACCESS;
                ACCESS:  if (pready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // The address is captured with the request and held for the whole transfer.
    always_ff @(posedge clk) begin
        if (state == IDLE && mem.req) begin
            addr_q <= mem.req_addr;
        end
    end

    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);
    assign pwrite  = 1'b0;              // Instruction fetch only reads.
    assign paddr   = addr_q;

    assign mem.busy       = (state != IDLE);
    assign mem.resp_valid = (state == ACCESS) && pready;
    assign mem.resp_data  = prdata;

    // ACCESS is entered only from the SETUP cycle of the same transfer.
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel && $past(psel && !penable)
    );

    // A stretched ACCESS phase keeps the same transfer on the bus.
    a_access_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (penable && !pready) |=> (penable && $stable(paddr))
    );

endmodule

//--- rtl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Fetch restarts here when reset is released.
`define FETCH_RESET_PC 32'h0000_0000

// Must be a power of two so the queue pointers wrap cleanly.
`define FETCH_QUEUE_DEPTH 4

`endif

//--- rtl/fetch_mem_if.sv
interface fetch_mem_if
    import fetch_pkg::*;
();

    logic       req;        // One-cycle request strobe.
    addr_t      req_addr;
    logic       busy;       // High from the cycle after req until resp_valid.
    logic       resp_valid;
    inst_word_t resp_data;

    modport requester (
        output req, req_addr,
        input  busy, resp_valid, resp_data
    );

    modport master (
        input  req, req_addr,
        output busy, resp_valid, resp_data
    );

endinterface

//--- rtl/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_word_t; // A 16-bit instruction sits in bits 15:0.

    // One extra bit above the index tells a full queue from an empty one.
    typedef logic [$clog2(`FETCH_QUEUE_DEPTH):0] qptr_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

    typedef enum logic [1:0] {
        RUN,
        WAIT_RESP,
        HALTED
    } seq_state_t;

endpackage

//--- rtl/fetch_queue.sv
`include "fetch_defines.svh"

module fetch_queue
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       push,
    input  logic       push_compressed,
    input  inst_word_t push_data,
    input  addr_t      push_pc,
    output logic       full,
    output logic       inst_valid,
    output logic       inst_compressed,
    output inst_word_t inst_data,
    output addr_t      inst_pc,
    input  logic       inst_ready
);

    localparam int IDX_W = $clog2(`FETCH_QUEUE_DEPTH);

    inst_word_t data_mem [`FETCH_QUEUE_DEPTH];
    addr_t      pc_mem   [`FETCH_QUEUE_DEPTH];
    logic       cmp_mem  [`FETCH_QUEUE_DEPTH];

    qptr_t wr_ptr;
    qptr_t rd_ptr;
    logic  pop;

    // Same index with different wrap bits means every slot is taken.
    assign full = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                  (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
    assign inst_valid = (wr_ptr != rd_ptr);
    assign pop        = inst_valid && inst_ready;

    assign inst_data       = data_mem[rd_ptr[IDX_W-1:0]];
    assign inst_pc         = pc_mem[rd_ptr[IDX_W-1:0]];
    assign inst_compressed = cmp_mem[rd_ptr[IDX_W-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;   // Flush wins over a push in the same cycle.
            rd_ptr <= '0;
        end else begin
            if (push && !full) wr_ptr <= wr_ptr + qptr_t'(1);
            if (pop) rd_ptr <= rd_ptr + qptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full && !flush) begin
            data_mem[wr_ptr[IDX_W-1:0]] <= push_data;
            pc_mem[wr_ptr[IDX_W-1:0]]   <= push_pc;
            cmp_mem[wr_ptr[IDX_W-1:0]]  <= push_compressed;
        end
    end

endmodule

//--- rtl/fetch_sequencer.sv
`include "fetch_defines.svh"

module fetch_sequencer
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    fetch_mem_if.requester mem,
    input  logic          redirect_valid,
    input  addr_t         redirect_pc,
    input  logic          queue_full,
    output logic          push,
    output logic          push_compressed,
    output logic          flush,
    output inst_word_t    push_data,
    output addr_t         push_pc
);

    seq_state_t state;
    addr_t      pc;
    logic       stale;      // The transfer in flight belongs to an abandoned path.
    logic       pd_stop;
    addr_t      pd_next_pc;

    next_pc_predecoder predecoder_i (
        .pc         (pc),
        .word       (mem.resp_data),
        .compressed (push_compressed),
        .stop       (pd_stop),
        .next_pc    (pd_next_pc)
    );

    // A request never goes out on a redirect cycle because the PC is about to change.
    assign mem.req      = (state == RUN) && !queue_full && !redirect_valid;
    assign mem.req_addr = pc;

    assign push      = (state == WAIT_RESP) && mem.resp_valid && !stale && !redirect_valid;
    assign push_data = mem.resp_data;
    assign push_pc   = pc;
    assign flush     = redirect_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUN;
            pc    <= `FETCH_RESET_PC;
            stale <= 1'b0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
            if (state == WAIT_RESP && !mem.resp_valid) begin
                stale <= 1'b1;  // Wait out the old response before starting over.
            end else begin
                state <= RUN;
                stale <= 1'b0;
            end
        end else begin
            case (state)
                RUN: begin
                    if (mem.req) state <= WAIT_RESP;
                end
                WAIT_RESP: begin
                    if (mem.resp_valid) begin
                        if (stale) begin
                            stale <= 1'b0;
                            state <= RUN;
                        end else begin
                            pc    <= pd_next_pc;
                            state <= pd_stop ? HALTED : RUN;
                        end
                    end
                end
                HALTED: state <= HALTED; // Only a redirect gets fetch going again.
                default: state <= RUN;
            endcase
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !queue_full
    );

    a_req_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n) mem.req |-> !mem.busy
    );

endmodule

//--- rtl/fetch_top.sv
module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output addr_t      paddr,
    input  inst_word_t prdata,
    input  logic       pready,
    input  logic       redirect_valid,
    input  addr_t      redirect_pc,
    output logic       inst_valid,
    output inst_word_t inst_data,
    output addr_t      inst_pc,
    output logic       inst_compressed,
    input  logic       inst_ready
);

    logic       queue_full;
    logic       push;
    logic       push_compressed;
    logic       flush;
    inst_word_t push_data;
    addr_t      push_pc;

    fetch_mem_if mem_if ();

    fetch_apb_master apb_master_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem     (mem_if.master),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .prdata  (prdata),
        .pready  (pready)
    );

    fetch_sequencer sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem             (mem_if.requester),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .queue_full      (queue_full),
        .push            (push),
        .push_compressed (push_compressed),
        .flush           (flush),
        .push_data       (push_data),
        .push_pc         (push_pc)
    );

    fetch_queue queue_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .push            (push),
        .push_compressed (push_compressed),
        .push_data       (push_data),
        .push_pc         (push_pc),
        .full            (queue_full),
        .inst_valid      (inst_valid),
        .inst_compressed (inst_compressed),
        .inst_data       (inst_data),
        .inst_pc         (inst_pc),
        .inst_ready      (inst_ready)
    );

endmodule

//--- rtl/next_pc_predecoder.sv
module next_pc_predecoder
    import fetch_pkg::*;
(
    input  addr_t      pc,
    input  inst_word_t word,
    output logic       compressed,
    output logic       stop,
    output addr_t      next_pc
);

    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    logic  is_jal;
    logic  is_jalr;
    logic  is_cj;
    logic  is_cjr;
    addr_t jal_imm;
    addr_t cj_imm;

    assign compressed = (word[1:0] != 2'b11);

    assign is_jal  = !compressed && (word[6:0] == OPC_JAL);
    assign is_jalr = !compressed && (word[6:0] == OPC_JALR);

    // C.J lives in quadrant 1 with funct3 101.
    assign is_cj = (word[1:0] == 2'b01) && (word[15:13] == 3'b101);

    // Covers C.JR and C.JALR alike, since bit 12 only selects the link.
    assign is_cjr = (word[1:0] == 2'b10) && (word[15:13] == 3'b100) &&
                    (word[6:2] == 5'd0) && (word[11:7] != 5'd0);

    assign jal_imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    assign cj_imm = {{21{word[12]}}, word[8], word[10:9], word[6], word[7],
                     word[2], word[11], word[5:3], 1'b0};

    assign stop = is_jalr || is_cjr; // Register targets are unknown here.

    always_comb begin
        if (is_jal) begin
            next_pc = pc + jal_imm;
        end else if (is_cj) begin
            next_pc = pc + cj_imm;
        end else if (compressed) begin
            next_pc = pc + 32'd2;
        end else begin
            next_pc = pc + 32'd4; // Branches fall through, predicted not taken.
        end
    end

endmodule

//--- test/fetch_tb.sv
`include "fetch_defines.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int MAX_CYCLES = 4000; // Several times the length of all the tests together.

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    addr_t      paddr;
    inst_word_t prdata;
    logic       pready;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       inst_valid;
    inst_word_t inst_data;
    addr_t      inst_pc;
    logic       inst_compressed;
    logic       inst_ready;
    int         cycles;

    fetch_top dut_i (.*);
    fetch_tb_mem mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= MAX_CYCLES) abort_run("Timeout: the tests did not finish in time.");
        end
    end

    // Fetch only ever reads from instruction memory.
    always @(posedge clk) begin
        if (rst_n && psel && pwrite !== 1'b0) begin
            abort_run("The fetch unit started a write transfer on APB.");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_word(input inst_word_t got, input inst_word_t exp,
                              input logic got_c, input logic exp_c, input string what);
        if (got !== exp || got_c !== exp_c) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %h/%b, expected %h/%b",
                                $time, what, got, got_c, exp, exp_c));
        end
    endtask

    // Reference prediction from the ISA encodings. JAL and C.J jump.
    // JALR, C.JR and C.JALR halt, and everything else is sequential.
    function automatic addr_t predict_next_pc(input addr_t pc, input inst_word_t w,
                                              output logic is16, output logic halts);
        logic [20:0] j_off;
        logic [11:0] cj_off;
        j_off  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        cj_off = {w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
        is16   = (w[1:0] != 2'b11);
        halts  = (!is16 && w[6:0] == 7'b1100111) ||
                 (w[1:0] == 2'b10 && w[15:13] == 3'b100 && w[6:2] == 5'd0 && w[11:7] != 5'd0);
        if (!is16 && w[6:0] == 7'b1101111) return pc + {{11{j_off[20]}}, j_off};
        if (w[1:0] == 2'b01 && w[15:13] == 3'b101) return pc + {{20{cj_off[11]}}, cj_off};
        return pc + (is16 ? 32'd2 : 32'd4);
    endfunction

    task automatic redirect_to(input addr_t target);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic pop_and_check(input addr_t start, input int count);
        addr_t      pc;
        addr_t      next_pc;
        inst_word_t word;
        logic       is16;
        logic       halts;
        pc = start;
        inst_ready <= 1'b1;
        for (int i = 0; i < count; i++) begin
            word    = mem_i.read_word(pc);
            next_pc = predict_next_pc(pc, word, is16, halts);
            do @(posedge clk); while (!(inst_valid && inst_ready));
            check_addr(inst_pc, pc, "inst_pc");
            check_word(inst_data, word, inst_compressed, is16, "inst_data");
            pc = next_pc;
        end
        inst_ready <= 1'b0;
        if (halts) expect_quiet(30); // Fetch stays stopped until the next redirect.
    endtask

    task automatic expect_quiet(input int window);
        inst_ready <= 1'b1;
        repeat (window) begin
            @(posedge clk);
            if (inst_valid) abort_run("An instruction was delivered after a JALR or C.JR.");
        end
        inst_ready <= 1'b0;
    endtask

    task automatic sequential_fetch();
        for (int i = 0; i < 8; i++) begin
            mem_i.write_word(32'h100 + addr_t'(4 * i), 32'h0010_8093 + inst_word_t'(i << 20));
        end
        redirect_to(32'h100);
        pop_and_check(32'h100, 8);
    endtask

    task automatic mixed_sizes();
        mem_i.write_half(32'h200, 16'h0085);
        mem_i.write_word(32'h202, 32'h0020_8093); // 32-bit at an address 2 mod 4.
        mem_i.write_half(32'h206, 16'h0089);
        mem_i.write_half(32'h208, 16'h0001);
        mem_i.write_word(32'h20a, 32'h0030_8093);
        mem_i.write_word(32'h20e, 32'h0040_8093);
        mem_i.write_half(32'h212, 16'h0085);
        mem_i.write_word(32'h214, 32'h0050_8093);
        redirect_to(32'h200);
        pop_and_check(32'h200, 8);
    endtask

    task automatic jump_prediction();
        mem_i.write_word(32'h300, 32'h0080_006f); // jal x0, +8
        mem_i.write_word(32'h304, 32'h0010_8093);
        mem_i.write_word(32'h308, 32'h0000_0863); // beq x0, x0, +16
        mem_i.write_half(32'h30c, 16'ha019);      // c.j +6
        mem_i.write_half(32'h30e, 16'h0001);
        mem_i.write_half(32'h310, 16'hbff5);      // c.j -4
        mem_i.write_word(32'h312, 32'hffdf_f06f); // jal x0, -4
        redirect_to(32'h300);
        pop_and_check(32'h300, 10);
    endtask

    task automatic stop_and_redirect();
        mem_i.write_word(32'h400, 32'h0010_8093);
        mem_i.write_half(32'h404, 16'h0085);
        mem_i.write_word(32'h406, 32'h0000_8067); // jalr x0, 0(x1)
        mem_i.write_half(32'h480, 16'h0089);
        mem_i.write_half(32'h482, 16'h8082);      // c.jr x1
        redirect_to(32'h400);
        pop_and_check(32'h400, 3);
        redirect_to(32'h480);
        pop_and_check(32'h480, 2);
        redirect_to(32'h100);
        pop_and_check(32'h100, 4);
    endtask

    task automatic back_pressure();
        redirect_to(32'h200);
        repeat (16 * `FETCH_QUEUE_DEPTH) @(posedge clk);
        if (!inst_valid) abort_run("The queue held nothing while decode was stalled.");
        pop_and_check(32'h200, 8);
    endtask

    task automatic redirect_in_flight();
        addr_t old_pcs [3] = '{32'h100, 32'h300, 32'h200};
        addr_t new_pcs [3] = '{32'h300, 32'h200, 32'h100};
        for (int k = 0; k < 3; k++) begin
            redirect_to(old_pcs[k]);
            inst_ready <= 1'b1;
            // Stalled in ACCESS with at least one more wait state to go.
            do @(posedge clk); while (!(psel && penable && !pready && mem_i.wait_left > 1));
            inst_ready <= 1'b0;
            redirect_to(new_pcs[k]);
            pop_and_check(new_pcs[k], 6);
        end
    endtask

    initial begin
        void'($urandom(85920));
        rst_n          <= 1'b0;
        redirect_valid <= 1'b0;
        redirect_pc    <= '0;
        inst_ready     <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        sequential_fetch();
        mixed_sizes();
        jump_prediction();
        stop_and_redirect();
        back_pressure();
        redirect_in_flight();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- test/fetch_tb_mem.sv
module fetch_tb_mem
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       psel,
    input  logic       penable,
    input  addr_t      paddr,
    output inst_word_t prdata,
    output logic       pready
);

    logic [15:0] halves [0:1023];
    logic [9:0]  idx;
    int          draw;
    int          wait_left;

    // Every halfword starts as a distinct C.ADDI built from its own index.
    initial begin
        for (int i = 0; i < 1024; i++) begin
            halves[i] = {4'b0000, i[9:0], 2'b01};
        end
    end

    task automatic write_half(input addr_t addr, input logic [15:0] half);
        halves[addr[10:1]] = half;
    endtask

    task automatic write_word(input addr_t addr, input inst_word_t word);
        write_half(addr, word[15:0]);
        write_half(addr + 32'd2, word[31:16]);
    endtask

    function automatic inst_word_t read_word(input addr_t addr);
        return {halves[addr[10:1] + 10'd1], halves[addr[10:1]]};
    endfunction

    assign idx    = paddr[10:1];
    assign prdata = {halves[idx + 10'd1], halves[idx]}; // Any halfword address works.

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready    <= 1'b0;
            wait_left <= 0;
        end else if (psel && !penable) begin
            draw = $urandom % 4;            // Wait states for this transfer.
            wait_left <= draw;
            pready    <= (draw == 0);
        end else if (psel && penable && !pready) begin
            wait_left <= wait_left - 1;
            pready    <= (wait_left == 1);
        end else begin
            pready <= 1'b0;
        end
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_mem_if.sv
rtl/fetch_apb_master.sv
rtl/next_pc_predecoder.sv
rtl/fetch_sequencer.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
test/fetch_tb_mem.sv
test/fetch_tb.sv
